// ==== Makefile ====
# Verilator build and run for tsp_anneal.
VERILATOR ?= verilator
TOP       ?= tsp_anneal_tb
FILELIST  ?= tsp_anneal.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Regression failed

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tsp_anneal_assert.sv ====
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module tsp_anneal_assert (
    input logic                          clk,
    input logic                          reset,
    input logic                          move_valid,
    input logic [anneal_pkg::lane_w-1:0] move_lane,
    input logic [1:0]                    move_command,
    input logic [`TSP_IDX_W-1:0]         move_k,
    input logic [`TSP_IDX_W-1:0]         move_l
);

    import tsp_move_pkg::*;

    lane_in_range: assert property (@(posedge clk) disable iff (reset)
        move_valid |-> int'(move_lane) < `TSP_REPLICAS)
        else $error("move_lane %0d is not a replica", move_lane);

    two_opt_ordered: assert property (@(posedge clk) disable iff (reset)
        (move_valid && move_command == cmd_two_opt) |-> move_k < move_l)
        else $error("2-opt move with k %0d not below l %0d", move_k, move_l);

    // A target next to the segment or on it leaves the tour unchanged.
    or_opt_moves: assert property (@(posedge clk) disable iff (reset)
        (move_valid && move_command == cmd_or_opt) |->
        (move_l != move_k && move_l != move_k - `TSP_IDX_W'(1)))
        else $error("or-opt move with k %0d and l %0d is no move", move_k, move_l);

    // Nothing is pending or done when reset is released.
    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !move_valid)
        else $error("move_valid high in the cycle after reset");

endmodule

bind move_collector tsp_anneal_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .move_valid   (move_valid),
    .move_lane    (move_lane),
    .move_command (move_command),
    .move_k       (move_k),
    .move_l       (move_l)
);

// ==== dv/tsp_anneal_tb.sv ====
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module tsp_anneal_tb;

    import tsp_move_pkg::*;
    import anneal_pkg::*;

    localparam int num_rows = 5;
    localparam int city_num = `TSP_CITY_NUM;

    logic                     clk;
    logic                     reset;
    logic                     seed_load;
    logic [63:0]              base_seed;
    logic                     run;
    logic [1:0]               run_command;
    logic [`TSP_REPLICAS-1:0] lane_mask;
    logic                     seeds_ready;
    logic                     move_valid;
    logic [lane_w-1:0]        move_lane;
    logic [1:0]               move_command;
    logic [`TSP_IDX_W-1:0]    move_k;
    logic [`TSP_IDX_W-1:0]    move_l;
    logic [`TSP_IDX_W-1:0]    move_span;
    logic [31:0]              move_r_metropolis;
    logic [31:0]              move_r_exchange;

    logic [63:0]              row_seed [num_rows];
    logic [1:0]               row_cmd [num_rows];
    logic [`TSP_REPLICAS-1:0] row_mask [num_rows];
    int                       row_runs [num_rows];

    logic [63:0] model_state [`TSP_REPLICAS];     // Xorshift state of each lane.
    int          exp_k [`TSP_REPLICAS];
    int          exp_l [`TSP_REPLICAS];
    int          exp_span [`TSP_REPLICAS];
    int          exp_steps [`TSP_REPLICAS];
    logic [31:0] exp_rm [`TSP_REPLICAS];
    logic [31:0] exp_re [`TSP_REPLICAS];

    int mismatch_cnt = 0;
    int fail_cnt = 0;
    int cycle_cnt = 0;
    int seed_var = 32'h4f95_853a;
    bit table_ready = 1'b0;

    tsp_anneal_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        return x ^ (x << 17);
    endfunction

    task automatic fill_table();
        row_seed[0] = 64'h0123_4567_89ab_cdef;
        row_cmd[0]  = cmd_two_opt;
        row_mask[0] = 'hf;
        row_runs[0] = 3;
        row_seed[1] = 64'hfedc_ba98_7654_3210;
        row_cmd[1]  = cmd_or_opt;
        row_mask[1] = 'hf;
        row_runs[1] = 3;
        row_seed[2] = 64'h1357_9bdf_2468_ace0;
        row_cmd[2]  = cmd_two_opt;
        row_mask[2] = 'h5;
        row_runs[2] = 2;
        row_seed[3] = 64'h0f1e_2d3c_4b5a_6978;
        row_cmd[3]  = cmd_or_opt;
        row_mask[3] = 'ha;
        row_runs[3] = 2;
        row_seed[4] = 64'hc391_0c8d_016b_07d6;   // Base plus two steps wraps to zero for lane 1.
        row_cmd[4]  = cmd_two_opt;
        row_mask[4] = 'hf;
        row_runs[4] = 2;
    endtask

    task automatic derive_seeds(input logic [63:0] base);
        logic [63:0] s;
        s = base;
        for (int i = 0; i < `TSP_REPLICAS; i++) begin
            s = s + seed_step;
            model_state[i] = (s == 64'd0) ? 64'd1 : s;
        end
    endtask

    // Rejection sampling for one lane, one step per busy cycle.
    task automatic predict_move(input int lane, input logic [1:0] cmd);
        logic [63:0] s;
        logic [31:0] mask;
        int          c;
        int          k;
        int          l;
        int          stage;
        int          steps;
        int          k_hi;
        int          l_lo;
        s     = model_state[lane];
        mask  = (cmd == cmd_two_opt) ? (32'd1 << mask_w_two) - 32'd1
                                     : (32'd1 << mask_w_or) - 32'd1;
        k_hi  = (cmd == cmd_two_opt) ? city_num : city_num - 1;
        l_lo  = (cmd == cmd_two_opt) ? 1 : 0;
        k     = 0;
        l     = 0;
        stage = 0;
        steps = 0;
        while (stage < 2 && steps < 100000) begin
            s = xorshift(s);
            steps++;
            c = int'(s[31:0] & mask);
            if (stage == 0) begin
                if (c >= 1 && c <= k_hi) begin
                    k     = c;
                    stage = 1;
                end
            end else if (c >= l_lo && c <= k_hi) begin
                if (c == k || (cmd == cmd_or_opt && c == k - 1)) begin
                    stage = 0;
                end else begin
                    l     = c;
                    stage = 2;
                end
            end
        end
        if (stage < 2) begin
            $display("error at %0t: model found no move for lane %0d", $time, lane);
            fail_cnt++;
        end
        s = xorshift(s);
        exp_rm[lane] = s[31:0];
        s = xorshift(s);
        exp_re[lane] = s[31:0];
        exp_steps[lane] = steps + 2;
        model_state[lane] = s;
        if (cmd == cmd_two_opt) begin
            exp_k[lane]    = (k < l) ? k : l;
            exp_l[lane]    = (k < l) ? l : k;
            exp_span[lane] = exp_l[lane] - exp_k[lane] + 1;
        end else begin
            exp_k[lane]    = k;
            exp_l[lane]    = l;
            exp_span[lane] = (k > l) ? k - l - 1 : l - k;
        end
    endtask

    task automatic check_val(input string what, input int lane, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: lane %0d %s got %0h expected %0h",
                     $time, lane, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_move(input int lane, input logic [1:0] cmd, input int run_cyc);
        int first;
        int last;
        first = run_cyc + 3 + exp_steps[lane];   // Done plus one collector cycle.
        last  = run_cyc + 2 + exp_steps[lane] + `TSP_REPLICAS;
        check_val("command", lane, 64'(move_command), 64'(cmd));
        check_val("k", lane, 64'(move_k), 64'(exp_k[lane]));
        check_val("l", lane, 64'(move_l), 64'(exp_l[lane]));
        check_val("span", lane, 64'(move_span), 64'(exp_span[lane]));
        check_val("r_metropolis", lane, 64'(move_r_metropolis), 64'(exp_rm[lane]));
        check_val("r_exchange", lane, 64'(move_r_exchange), 64'(exp_re[lane]));
        if (cycle_cnt < first || cycle_cnt > last) begin
            $display("error at %0t: lane %0d move came in cycle %0d, not in %0d to %0d",
                     $time, lane, cycle_cnt, first, last);
            fail_cnt++;
        end
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            if (move_valid) begin
                $display("error at %0t: a move came out with no run pending", $time);
                fail_cnt++;
            end
        end
    endtask

    task automatic load_seeds(input logic [63:0] base);
        int wait_cyc;
        seed_load = 1'b1;
        base_seed = base;
        @(posedge clk);
        #1;
        seed_load   = 1'b0;
        run         = 1'b1;                    // Seeds not ready yet, so no lane starts.
        run_command = cmd_two_opt;
        lane_mask   = '1;
        wait_cyc    = 1;
        while (!seeds_ready && wait_cyc < 20) begin
            @(posedge clk);
            #1;
            run = 1'b0;
            wait_cyc++;
            if (move_valid) begin
                $display("error at %0t: a move came out while seeds were loading", $time);
                fail_cnt++;
            end
        end
        if (wait_cyc != `TSP_REPLICAS + 1) begin
            $display("mismatch at %0t: seeds_ready after %0d cycles, expected %0d",
                     $time, wait_cyc, `TSP_REPLICAS + 1);
            mismatch_cnt++;
        end
        run = 1'b0;
        idle_cycles(8);
    endtask

    task automatic apply_run(input logic [1:0] cmd, input logic [`TSP_REPLICAS-1:0] mask);
        bit seen [`TSP_REPLICAS];
        int run_cyc;
        int got;
        int lane;
        for (int i = 0; i < `TSP_REPLICAS; i++) begin
            seen[i] = 1'b0;
            if (mask[i]) begin
                predict_move(i, cmd);
            end
        end
        run         = 1'b1;
        run_command = cmd;
        lane_mask   = mask;
        run_cyc     = cycle_cnt;
        got         = 0;
        @(posedge clk);
        #1;
        run = 1'b0;
        while (got < $countones(mask)) begin
            @(posedge clk);
            #1;
            if (move_valid) begin
                lane = int'(move_lane);
                if (!mask[lane] || seen[lane]) begin
                    $display("error at %0t: lane %0d reported a move it was not started for",
                             $time, lane);
                    fail_cnt++;
                end else begin
                    seen[lane] = 1'b1;
                    got++;
                    check_move(lane, cmd, run_cyc);
                end
            end
        end
    endtask

    initial begin
        int total_runs;
        wait (table_ready);
        total_runs = 0;
        for (int i = 0; i < num_rows; i++) begin
            total_runs += row_runs[i];
        end
        #(total_runs * 300 * 100);
        $display("timeout: the moves did not all arrive before the watchdog expired");
        $display("Regression failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        seed_load   = 1'b0;
        base_seed   = '0;
        run         = 1'b0;
        run_command = cmd_none;
        lane_mask   = '0;
        fill_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        run         = 1'b1;                    // Dropped, nothing is seeded after reset.
        run_command = cmd_two_opt;
        lane_mask   = '1;
        @(posedge clk);
        #1;
        run = 1'b0;
        idle_cycles(10);
        for (int r = 0; r < num_rows; r++) begin
            load_seeds(row_seed[r]);
            derive_seeds(row_seed[r]);
            for (int n = 0; n < row_runs[r]; n++) begin
                apply_run(row_cmd[r], row_mask[r]);
                idle_cycles(1 + ($unsigned($random(seed_var)) % 8));
            end
        end
        $display("done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hw/anneal_pkg.sv ====
`include "tsp_cfg.svh"

package anneal_pkg;

    localparam int replicas = `TSP_REPLICAS;

    // At least one bit even for a single replica.
    localparam int lane_w = (replicas > 1) ? $clog2(replicas) : 1;

    // Golden-ratio increment, keeps the lane seeds well spread.
    localparam logic [63:0] seed_step = 64'h9E37_79B9_7F4A_7C15;

endpackage

// ==== hw/move_collector.sv ====
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module move_collector (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [`TSP_REPLICAS-1:0]              lane_done,
    input  logic [2*`TSP_REPLICAS-1:0]            lane_command,
    input  logic [2*`TSP_IDX_W*`TSP_REPLICAS-1:0] lane_move,
    input  logic [32*`TSP_REPLICAS-1:0]           lane_r_metropolis,
    input  logic [32*`TSP_REPLICAS-1:0]           lane_r_exchange,
    output logic                                  move_valid,
    output logic [anneal_pkg::lane_w-1:0]         move_lane,
    output logic [1:0]                            move_command,
    output logic [`TSP_IDX_W-1:0]                 move_k,
    output logic [`TSP_IDX_W-1:0]                 move_l,
    output logic [`TSP_IDX_W-1:0]                 move_span,
    output logic [31:0]                           move_r_metropolis,
    output logic [31:0]                           move_r_exchange
);

    import tsp_move_pkg::*;
    import anneal_pkg::*;

    localparam int move_w = $bits(move_word_u);

    logic [`TSP_REPLICAS-1:0] pending;
    logic [`TSP_REPLICAS-1:0] req;
    logic [`TSP_REPLICAS-1:0] grant;
    logic [lane_w-1:0]        last_lane;
    logic [lane_w-1:0]        pick;
    logic                     found;
    move_word_u               sel_word;

    assign req = pending | lane_done;                 // A fresh done can go out at once.

    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last_lane;
        for (int i = 1; i <= replicas; i++) begin
            idx = (int'(last_lane) + i) % replicas;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = lane_w'(idx);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= '0;
            move_valid <= 1'b0;
            last_lane  <= lane_w'(replicas - 1);  // Lane 0 is searched first.
        end else begin
            pending    <= req & ~grant;
            move_valid <= found;
            if (found) begin
                last_lane <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            move_lane         <= pick;
            move_command      <= lane_command[pick*2 +: 2];
            sel_word          <= lane_move[pick*move_w +: move_w];
            move_r_metropolis <= lane_r_metropolis[pick*32 +: 32];
            move_r_exchange   <= lane_r_exchange[pick*32 +: 32];
        end
    end

    // Span is the number of tour positions the move reorders.
    always_comb begin
        if (move_command == cmd_two_opt) begin
            move_k    = sel_word.two_opt.seg_lo;
            move_l    = sel_word.two_opt.seg_hi;
            move_span = sel_word.two_opt.seg_hi - sel_word.two_opt.seg_lo + 1'b1;
        end else begin
            move_k = sel_word.or_opt.src;
            move_l = sel_word.or_opt.dst;
            if (sel_word.or_opt.src > sel_word.or_opt.dst) begin
                move_span = sel_word.or_opt.src - sel_word.or_opt.dst - 1'b1;
            end else begin
                move_span = sel_word.or_opt.dst - sel_word.or_opt.src;
            end
        end
    end

endmodule

// ==== hw/move_proposer.sv ====
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module move_proposer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     init,
    input  logic [63:0]              seed,
    input  logic                     start,
    input  logic [1:0]               start_command,
    output logic                     busy,
    output logic                     done,
    output logic [1:0]               command,
    output tsp_move_pkg::move_word_u move,
    output logic [31:0]              r_metropolis,
    output logic [31:0]              r_exchange
);

    import tsp_move_pkg::*;

    localparam logic [1:0] st_k     = 2'd0;
    localparam logic [1:0] st_l     = 2'd1;
    localparam logic [1:0] st_metro = 2'd2;
    localparam logic [1:0] st_exch  = 2'd3;

    localparam logic [31:0] city_num = 32'(`TSP_CITY_NUM);
    localparam logic [31:0] mask_two = (32'd1 << mask_w_two) - 32'd1;
    localparam logic [31:0] mask_or  = (32'd1 << mask_w_or) - 32'd1;

    logic [63:0]           rng_state;
    logic [63:0]           x1;
    logic [63:0]           x2;
    logic [63:0]           next_state;
    logic [31:0]           mask;
    logic [31:0]           cand;
    logic [`TSP_IDX_W-1:0] cand_idx;
    logic [`TSP_IDX_W-1:0] k_cur;
    logic [1:0]            fsm_state;
    logic                  is_two;
    logic                  k_ok;
    logic                  l_ok;
    logic                  l_reject;

    always_comb begin
        x1         = rng_state ^ (rng_state << 13);
        x2         = x1 ^ (x1 >> 7);
        next_state = x2 ^ (x2 << 17);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rng_state <= '0;
        end else if (init) begin
            rng_state <= seed;
        end else if (busy) begin
            rng_state <= next_state;              // One step per busy cycle.
        end
    end

    assign is_two = (command == cmd_two_opt);

    // Narrow mask for the index draws, full width once both indices stand.
    always_comb begin
        if (fsm_state == st_k || fsm_state == st_l) begin
            mask = is_two ? mask_two : mask_or;
        end else begin
            mask = '1;
        end
    end

    assign cand     = next_state[31:0] & mask;
    assign cand_idx = cand[`TSP_IDX_W-1:0];

    // K is parked in the view of the current command until L arrives.
    assign k_cur = is_two ? move.two_opt.seg_lo : move.or_opt.src;

    assign k_ok = is_two ? (cand >= 32'd1 && cand <= city_num)
                         : (cand >= 32'd1 && cand <= city_num - 32'd1);
    assign l_ok = is_two ? (cand >= 32'd1 && cand <= city_num)
                         : (cand <= city_num - 32'd1);

    // Equal indices or an or-opt segment next to its own target are no move.
    assign l_reject = is_two ? (cand_idx == k_cur)
                             : (cand_idx == k_cur || cand_idx == k_cur - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            fsm_state <= st_k;
            command   <= cmd_none;
        end else begin
            done <= 1'b0;
            if (start && start_command != cmd_none) begin
                busy      <= 1'b1;
                fsm_state <= st_k;
                command   <= start_command;
            end else if (busy) begin
                case (fsm_state)
                    st_k: begin
                        if (k_ok) begin
                            fsm_state <= st_l;
                        end
                    end
                    st_l: begin
                        if (l_ok) begin
                            fsm_state <= l_reject ? st_k : st_metro;
                        end
                    end
                    st_metro: begin
                        fsm_state <= st_exch;
                    end
                    default: begin
                        busy      <= 1'b0;
                        done      <= 1'b1;
                        fsm_state <= st_k;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            case (fsm_state)
                st_k: begin
                    if (k_ok && is_two) begin
                        move.two_opt.seg_lo <= cand_idx;
                    end else if (k_ok) begin
                        move.or_opt.src <= cand_idx;
                    end
                end
                st_l: begin
                    if (l_ok && !l_reject) begin
                        if (!is_two) begin
                            move.or_opt.dst <= cand_idx;
                        end else if (cand_idx < k_cur) begin
                            move.two_opt.seg_lo <= cand_idx;
                            move.two_opt.seg_hi <= k_cur;
                        end else begin
                            move.two_opt.seg_hi <= cand_idx;
                        end
                    end
                end
                st_metro: begin
                    r_metropolis <= cand;
                end
                default: begin
                    r_exchange <= cand;
                end
            endcase
        end
    end

endmodule

// ==== hw/seed_distributor.sv ====
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module seed_distributor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     seed_load,
    input  logic [63:0]              base_seed,
    input  logic                     run,
    input  logic [1:0]               run_command,
    input  logic [`TSP_REPLICAS-1:0] lane_mask,
    input  logic [`TSP_REPLICAS-1:0] lane_busy,
    output logic                     seeds_ready,
    output logic [`TSP_REPLICAS-1:0] lane_init,
    output logic [63:0]              lane_seed,
    output logic [`TSP_REPLICAS-1:0] lane_start,
    output logic [1:0]               lane_command
);

    import tsp_move_pkg::*;
    import anneal_pkg::*;

    logic              loading;
    logic [lane_w-1:0] load_cnt;
    logic [63:0]       seed_acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            loading     <= 1'b0;
            load_cnt    <= '0;
            seeds_ready <= 1'b0;
        end else if (seed_load) begin
            loading     <= 1'b1;
            load_cnt    <= '0;
            seeds_ready <= 1'b0;
        end else if (loading) begin
            load_cnt <= load_cnt + 1'b1;
            if (load_cnt == lane_w'(replicas - 1)) begin
                loading     <= 1'b0;
                seeds_ready <= 1'b1;                  // One cycle after the last init.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seed_load) begin
            seed_acc <= base_seed + seed_step;
        end else if (loading) begin
            seed_acc <= seed_acc + seed_step;
        end
    end

    assign lane_seed = (seed_acc == 64'd0) ? 64'd1 : seed_acc;   // Xorshift locks up at zero.

    always_comb begin
        lane_init = '0;
        if (loading) begin
            lane_init[load_cnt] = 1'b1;
        end
    end

    // A lane with a start still in flight is not busy yet, so it is masked as well.
    always_ff @(posedge clk) begin
        if (reset) begin
            lane_start <= '0;
        end else if (run && run_command != cmd_none && seeds_ready) begin
            lane_start <= lane_mask & ~lane_busy & ~lane_start;
        end else begin
            lane_start <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            lane_command <= run_command;
        end
    end

endmodule

// ==== hw/tsp_anneal_top.sv ====
`timescale 1ns/1ps
`include "tsp_cfg.svh"

module tsp_anneal_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          seed_load,
    input  logic [63:0]                   base_seed,
    input  logic                          run,
    input  logic [1:0]                    run_command,
    input  logic [`TSP_REPLICAS-1:0]      lane_mask,
    output logic                          seeds_ready,
    output logic                          move_valid,
    output logic [anneal_pkg::lane_w-1:0] move_lane,
    output logic [1:0]                    move_command,
    output logic [`TSP_IDX_W-1:0]         move_k,
    output logic [`TSP_IDX_W-1:0]         move_l,
    output logic [`TSP_IDX_W-1:0]         move_span,
    output logic [31:0]                   move_r_metropolis,
    output logic [31:0]                   move_r_exchange
);

    localparam int move_w = 2 * `TSP_IDX_W;

    logic [`TSP_REPLICAS-1:0]        lane_init;
    logic [`TSP_REPLICAS-1:0]        lane_start;
    logic [`TSP_REPLICAS-1:0]        lane_busy;
    logic [`TSP_REPLICAS-1:0]        lane_done;
    logic [63:0]                     lane_seed;
    logic [1:0]                      lane_command;
    logic [2*`TSP_REPLICAS-1:0]      prop_command;
    logic [move_w*`TSP_REPLICAS-1:0] prop_move;
    logic [32*`TSP_REPLICAS-1:0]     prop_r_metropolis;
    logic [32*`TSP_REPLICAS-1:0]     prop_r_exchange;

    seed_distributor u_seed_distributor (
        .clk          (clk),
        .reset        (reset),
        .seed_load    (seed_load),
        .base_seed    (base_seed),
        .run          (run),
        .run_command  (run_command),
        .lane_mask    (lane_mask),
        .lane_busy    (lane_busy),
        .seeds_ready  (seeds_ready),
        .lane_init    (lane_init),
        .lane_seed    (lane_seed),
        .lane_start   (lane_start),
        .lane_command (lane_command)
    );

    for (genvar i = 0; i < `TSP_REPLICAS; i++) begin : g_lane
        move_proposer u_move_proposer (
            .clk           (clk),
            .reset         (reset),
            .init          (lane_init[i]),
            .seed          (lane_seed),
            .start         (lane_start[i]),
            .start_command (lane_command),
            .busy          (lane_busy[i]),
            .done          (lane_done[i]),
            .command       (prop_command[2*i +: 2]),
            .move          (prop_move[move_w*i +: move_w]),
            .r_metropolis  (prop_r_metropolis[32*i +: 32]),
            .r_exchange    (prop_r_exchange[32*i +: 32])
        );
    end

    move_collector u_move_collector (
        .clk               (clk),
        .reset             (reset),
        .lane_done         (lane_done),
        .lane_command      (prop_command),
        .lane_move         (prop_move),
        .lane_r_metropolis (prop_r_metropolis),
        .lane_r_exchange   (prop_r_exchange),
        .move_valid        (move_valid),
        .move_lane         (move_lane),
        .move_command      (move_command),
        .move_k            (move_k),
        .move_l            (move_l),
        .move_span         (move_span),
        .move_r_metropolis (move_r_metropolis),
        .move_r_exchange   (move_r_exchange)
    );

endmodule

// ==== hw/tsp_cfg.svh ====
`ifndef TSP_CFG_SVH
`define TSP_CFG_SVH

// Problem size and replica array shape.
`define TSP_CITY_NUM 12
`define TSP_REPLICAS 4

// Must hold city indices 0..TSP_CITY_NUM.
`define TSP_IDX_W    4

`endif

// ==== hw/tsp_move_pkg.sv ====
`include "tsp_cfg.svh"

package tsp_move_pkg;

    localparam logic [1:0] cmd_none    = 2'd0;
    localparam logic [1:0] cmd_or_opt  = 2'd1;
    localparam logic [1:0] cmd_two_opt = 2'd2;

    // Candidate masks for the K and L draws.
    localparam int mask_w_two = $clog2(`TSP_CITY_NUM);
    localparam int mask_w_or  = $clog2(`TSP_CITY_NUM - 1);

    // seg_hi shares its bits with src, seg_lo with dst.
    typedef union packed {
        struct packed {
            logic [`TSP_IDX_W-1:0] seg_hi;
            logic [`TSP_IDX_W-1:0] seg_lo;
        } two_opt;
        struct packed {
            logic [`TSP_IDX_W-1:0] src;
            logic [`TSP_IDX_W-1:0] dst;
        } or_opt;
    } move_word_u;

endpackage

// ==== tsp_anneal.f ====
+incdir+hw
hw/tsp_move_pkg.sv
hw/anneal_pkg.sv
hw/seed_distributor.sv
hw/move_proposer.sv
hw/move_collector.sv
hw/tsp_anneal_top.sv
dv/tsp_anneal_assert.sv
dv/tsp_anneal_tb.sv
